// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  core_pkg::alu_op_t         op,
    input  logic [core_pkg::xlen-1:0] a,
    input  logic [core_pkg::xlen-1:0] b,
    output logic [core_pkg::xlen-1:0] result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            core_pkg::alu_add:  result = a + b;
            core_pkg::alu_sub:  result = a - b;
            core_pkg::alu_sll:  result = a << shamt;
            core_pkg::alu_slt:  result = {31'd0, lt_signed};
            core_pkg::alu_sltu: result = {31'd0, lt_unsigned};
            core_pkg::alu_xor:  result = a ^ b;
            core_pkg::alu_srl:  result = a >> shamt;
            core_pkg::alu_sra:  result = $unsigned($signed(a) >>> shamt);  // keeps sign bit
            core_pkg::alu_or:   result = a | b;
            core_pkg::alu_and:  result = a & b;
            default:            result = a + b;
        endcase
    end

endmodule

// File: branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic [2:0]                funct3,
    input  logic [core_pkg::xlen-1:0] a,
    input  logic [core_pkg::xlen-1:0] b,
    input  logic                      branch,
    output logic                      branch_taken
);

    logic eq;
    logic lt;
    logic ltu;
    logic cond;

    assign eq  = (a == b);
    assign lt  = $signed(a) < $signed(b);
    assign ltu = a < b;

    always_comb begin
        case (funct3)
            core_pkg::f3_beq:  cond = eq;
            core_pkg::f3_bne:  cond = !eq;
            core_pkg::f3_blt:  cond = lt;
            core_pkg::f3_bge:  cond = !lt;
            core_pkg::f3_bltu: cond = ltu;
            core_pkg::f3_bgeu: cond = !ltu;
            default:           cond = 1'b0;
        endcase
    end

    assign branch_taken = branch && cond;

endmodule

// File: core_pkg.sv
package core_pkg;

    // data and address width
    localparam int xlen = 32;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_t;

    // major opcodes in instr[6:0]
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    // branch conditions in instr[14:12]
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

endpackage

// File: instruction_decoder.sv
`timescale 1ns/1ps

module instruction_decoder (
    input  logic [31:0]       instr,
    output core_pkg::alu_op_t alu_op,
    output logic [4:0]        rs1,
    output logic [4:0]        rs2,
    output logic [4:0]        rd,
    output logic [31:0]       immediate,
    output logic              alu_src_imm,
    output logic              mem_read,
    output logic              mem_write,
    output logic              reg_write,
    output logic              branch,
    output logic [2:0]        funct3
);

    logic [6:0]        opcode;
    logic              funct7_5;
    logic              funct7_zero;  // funct7 apart from bit 5
    logic [31:0]       imm_i;
    logic [31:0]       imm_s;
    logic [31:0]       imm_b;
    core_pkg::alu_op_t f3_op;
    logic              r_ok;
    logic              i_ok;
    logic              valid;
    logic              writes_rd;
    logic              is_load;
    logic              is_store;
    logic              is_branch;

    assign opcode   = instr[6:0];
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign funct7_5 = instr[30];

    assign funct7_zero = (instr[31] == 1'b0) && (instr[29:25] == 5'd0);

    // sign-extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // only sub and sra may set funct7 bit 5
    assign r_ok = funct7_zero && (!funct7_5 || funct3 == 3'b000 || funct3 == 3'b101);

    // shift immediates carry funct7 in the upper immediate bits
    assign i_ok = (funct3 != 3'b001 && funct3 != 3'b101) ||
                  (funct7_zero && (!funct7_5 || funct3 == 3'b101));

    always_comb begin
        case (funct3)
            3'b000:  f3_op = core_pkg::alu_add;
            3'b001:  f3_op = core_pkg::alu_sll;
            3'b010:  f3_op = core_pkg::alu_slt;
            3'b011:  f3_op = core_pkg::alu_sltu;
            3'b100:  f3_op = core_pkg::alu_xor;
            3'b101:  f3_op = funct7_5 ? core_pkg::alu_sra : core_pkg::alu_srl;
            3'b110:  f3_op = core_pkg::alu_or;
            default: f3_op = core_pkg::alu_and;
        endcase
    end

    always_comb begin
        alu_op      = core_pkg::alu_add;
        immediate   = '0;
        alu_src_imm = 1'b0;
        valid       = 1'b0;
        writes_rd   = 1'b0;
        is_load     = 1'b0;
        is_store    = 1'b0;
        is_branch   = 1'b0;

        case (opcode)
            core_pkg::op_reg: begin
                valid     = r_ok;
                writes_rd = 1'b1;
                if (funct3 == 3'b000 && funct7_5) begin
                    alu_op = core_pkg::alu_sub;
                end else begin
                    alu_op = f3_op;
                end
            end
            core_pkg::op_imm: begin
                valid       = i_ok;
                writes_rd   = 1'b1;
                alu_src_imm = 1'b1;
                immediate   = imm_i;
                alu_op      = f3_op;  // sra only reachable via funct3 101
            end
            core_pkg::op_load: begin
                valid       = (funct3 == 3'b010);  // lw only
                writes_rd   = 1'b1;
                is_load     = 1'b1;
                alu_src_imm = 1'b1;
                immediate   = imm_i;
            end
            core_pkg::op_store: begin
                valid       = (funct3 == 3'b010);  // sw only
                is_store    = 1'b1;
                alu_src_imm = 1'b1;
                immediate   = imm_s;
            end
            core_pkg::op_branch: begin
                valid     = (funct3[2:1] != 2'b01);
                is_branch = 1'b1;
                immediate = imm_b;
                alu_op    = core_pkg::alu_sub;
            end
            default: begin
                valid = 1'b0;  // retires as a no-op
            end
        endcase
    end

    // x0 as destination drops the write
    assign reg_write = valid && writes_rd && (rd != 5'd0);
    assign mem_read  = valid && is_load && (rd != 5'd0);
    assign mem_write = valid && is_store;
    assign branch    = valid && is_branch;

endmodule

// File: register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [4:0]               rs1,
    input  logic [4:0]               rs2,
    input  logic [4:0]               rd,
    input  logic [core_pkg::xlen-1:0] wdata,
    input  logic                     we,
    output logic [core_pkg::xlen-1:0] rs1_data,
    output logic [core_pkg::xlen-1:0] rs2_data
);

    logic [core_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 hardwired to zero
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: rv_core.sv
`timescale 1ns/1ps

module rv_core #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic                      clk,
    input  logic                      rst_n,

    output logic [core_pkg::xlen-1:0] imem_addr,
    input  logic [31:0]               imem_rdata,

    output logic [core_pkg::xlen-1:0] dmem_addr,
    output logic [core_pkg::xlen-1:0] dmem_wdata,
    output logic                      dmem_we,
    input  logic [core_pkg::xlen-1:0] dmem_rdata,

    output logic                      retire_valid,
    output logic [core_pkg::xlen-1:0] retire_pc,
    output logic                      wb_en,
    output logic [4:0]                wb_rd,
    output logic [core_pkg::xlen-1:0] wb_data
);

    logic [core_pkg::xlen-1:0] pc;
    logic [core_pkg::xlen-1:0] pc_next;
    logic                      running;  // low for one cycle after reset

    core_pkg::alu_op_t         alu_op;
    logic [4:0]                rs1;
    logic [4:0]                rs2;
    logic [4:0]                rd;
    logic [core_pkg::xlen-1:0] immediate;
    logic                      alu_src_imm;
    logic                      mem_read;
    logic                      mem_write;
    logic                      reg_write;
    logic                      branch;
    logic [2:0]                funct3;

    logic [core_pkg::xlen-1:0] rs1_data;
    logic [core_pkg::xlen-1:0] rs2_data;
    logic [core_pkg::xlen-1:0] alu_b;
    logic [core_pkg::xlen-1:0] alu_result;
    logic                      branch_taken;
    logic                      rf_we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= reset_pc;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            if (running) begin
                pc <= pc_next;
            end
        end
    end

    instruction_decoder u_decoder (
        .instr       (imem_rdata),
        .alu_op      (alu_op),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .immediate   (immediate),
        .alu_src_imm (alu_src_imm),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .reg_write   (reg_write),
        .branch      (branch),
        .funct3      (funct3)
    );

    register_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .wdata    (wb_data),
        .we       (rf_we),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign alu_b = alu_src_imm ? immediate : rs2_data;

    alu u_alu (
        .op     (alu_op),
        .a      (rs1_data),
        .b      (alu_b),
        .result (alu_result)
    );

    branch_unit u_branch (
        .funct3       (funct3),
        .a            (rs1_data),
        .b            (rs2_data),
        .branch       (branch),
        .branch_taken (branch_taken)
    );

    assign pc_next   = branch_taken ? (pc + immediate) : (pc + 32'd4);
    assign imem_addr = pc;

    // load/store address is the alu sum
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_data;
    assign dmem_we    = mem_write && running;

    assign rf_we   = reg_write && running;
    assign wb_data = mem_read ? dmem_rdata : alu_result;

    assign retire_valid = running;
    assign retire_pc    = pc;
    assign wb_en        = rf_we;
    assign wb_rd        = rd;

endmodule

// File: sources.f
+incdir+.
core_pkg.sv
instruction_decoder.sv
register_file.sv
alu.sv
branch_unit.sv
rv_core.sv
tb_rv_core.sv

// File: tb_iss.svh
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

// architectural reference state stepped once per retired instruction
logic [31:0] model_regs [32];
logic [31:0] model_mem [16];
logic [31:0] model_pc;

// expected effects of the instruction at model_pc
logic        exp_wb_en;
logic [4:0]  exp_wb_rd;
logic [31:0] exp_wb_data;
logic        exp_we;
logic [31:0] exp_addr;
logic [31:0] exp_wdata;
logic [31:0] exp_next_pc;

task automatic reset_model(input logic [31:0] start_pc);
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = 32'd0;
    end
    for (int i = 0; i < 16; i++) begin
        model_mem[i] = 32'd0;
    end
    model_pc = start_pc;
endtask

// rv32i integer semantics where alt selects sub or sra
function automatic logic [31:0] int_result(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
        3'b000:  r = alt ? a - b : a + b;
        3'b001:  r = a << b[4:0];
        3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  r = (a < b) ? 32'd1 : 32'd0;
        3'b100:  r = a ^ b;
        3'b101:  r = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

task automatic predict(input logic [31:0] instr);
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic        taken;
    rd    = instr[11:7];
    f3    = instr[14:12];
    a     = model_regs[instr[19:15]];
    b     = model_regs[instr[24:20]];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    taken = 1'b0;
    exp_wb_en   = 1'b0;
    exp_wb_rd   = rd;
    exp_wb_data = 32'd0;
    exp_we      = 1'b0;
    exp_addr    = 32'd0;
    exp_wdata   = 32'd0;
    case (instr[6:0])
        core_pkg::op_reg: begin
            exp_wb_en   = (rd != 5'd0);
            exp_wb_data = int_result(f3, instr[30], a, b);
        end
        core_pkg::op_imm: begin
            exp_wb_en   = (rd != 5'd0);
            exp_wb_data = int_result(f3, (f3 == 3'b101) && instr[30], a, imm_i);
        end
        core_pkg::op_load: begin
            exp_wb_en   = (rd != 5'd0);
            exp_wb_data = model_mem[4'((a + imm_i) >> 2)];
        end
        core_pkg::op_store: begin
            exp_we    = 1'b1;
            exp_addr  = a + imm_s;
            exp_wdata = b;
        end
        core_pkg::op_branch: begin
            case (f3)
                core_pkg::f3_beq:  taken = (a == b);
                core_pkg::f3_bne:  taken = (a != b);
                core_pkg::f3_blt:  taken = ($signed(a) < $signed(b));
                core_pkg::f3_bge:  taken = ($signed(a) >= $signed(b));
                core_pkg::f3_bltu: taken = (a < b);
                default:           taken = (a >= b);
            endcase
        end
        default: begin
            taken = 1'b0;  // unknown opcode has no effect
        end
    endcase
    exp_next_pc = taken ? model_pc + imm_b : model_pc + 32'd4;
endtask

task automatic commit_instruction();
    if (exp_wb_en) begin
        model_regs[exp_wb_rd] = exp_wb_data;
    end
    if (exp_we) begin
        model_mem[exp_addr[5:2]] = exp_wdata;
    end
    model_pc = exp_next_pc;
endtask

`endif

// File: tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam logic [31:0] boot_pc      = 32'h0000_0000;
    localparam int          reset_cycles = 10;
    localparam int          n_retire     = 1500;
    localparam int          max_cycles   = reset_cycles + n_retire + 90;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] program_mem [64];
    logic [31:0] data_mem [16];
    logic [15:0] lfsr_state;
    int          cycle_count;
    int          released_edges;  // rising edges seen with rst_n high
    int          retired;

    `include "tb_iss.svh"

    rv_core #(
        .reset_pc (boot_pc)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_we      (dmem_we),
        .dmem_rdata   (dmem_rdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

    always #50 clk = ~clk;

    assign imem_rdata = program_mem[imem_addr[7:2]];  // 256-byte wrap
    assign dmem_rdata = data_mem[dmem_addr[5:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            data_mem[dmem_addr[5:2]] <= dmem_wdata;
        end
    end

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    task automatic build_program();
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [12:0] boff;
        for (int i = 0; i < 64; i++) begin
            kind = 4'(take_bits(4));
            rd   = {2'b00, 3'(take_bits(3))};  // x0..x7 keeps dependencies dense
            rs1  = {2'b00, 3'(take_bits(3))};
            rs2  = {2'b00, 3'(take_bits(3))};
            f3   = 3'(take_bits(3));
            alt  = take_bits(1) == 32'd1;
            if (kind <= 4'd4) begin
                alt = alt && (f3 == 3'b000 || f3 == 3'b101);
                program_mem[i] = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, core_pkg::op_reg};
            end else if (kind <= 4'd8) begin
                imm = 12'(take_bits(12));
                if (f3 == 3'b001) begin
                    imm[11:5] = 7'd0;
                end else if (f3 == 3'b101) begin
                    imm[11:5] = {1'b0, alt, 5'd0};
                end
                program_mem[i] = {imm, rs1, f3, rd, core_pkg::op_imm};
            end else if (kind <= 4'd10) begin
                imm = {6'd0, 4'(take_bits(4)), 2'b00};
                program_mem[i] = {imm, 5'd0, 3'b010, rd, core_pkg::op_load};
            end else if (kind <= 4'd12) begin
                imm = {6'd0, 4'(take_bits(4)), 2'b00};
                program_mem[i] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], core_pkg::op_store};
            end else if (kind <= 4'd14) begin
                boff = {7'd0, 4'(take_bits(3)) + 4'd1, 2'b00};  // forward 1..8 words
                case (f3)
                    3'd0, 3'd6: f3 = core_pkg::f3_beq;
                    3'd1, 3'd7: f3 = core_pkg::f3_bne;
                    3'd2:       f3 = core_pkg::f3_blt;
                    3'd3:       f3 = core_pkg::f3_bge;
                    3'd4:       f3 = core_pkg::f3_bltu;
                    default:    f3 = core_pkg::f3_bgeu;
                endcase
                program_mem[i] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11],
                                  core_pkg::op_branch};
            end else begin
                program_mem[i] = {25'(take_bits(25)), alt ? 7'b1111111 : 7'b0001011};
            end
        end
    endtask

    task automatic end_with_failure();
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, expected);
            end_with_failure();
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        lfsr_state     = 16'd36125;
        cycle_count    = 0;
        released_edges = 0;
        retired        = 0;
        for (int i = 0; i < 16; i++) begin
            data_mem[i] = 32'd0;
        end
        reset_model(boot_pc);
        build_program();
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (rst_n) begin
            released_edges <= released_edges + 1;
        end
        if (cycle_count >= max_cycles) begin
            $display("Timed out after %0d cycles with %0d instructions retired",
                     cycle_count, retired);
            end_with_failure();
        end
    end

    always @(negedge clk) begin
        check_value("retire_valid", 32'(retire_valid), 32'(released_edges >= 1));
        if (!retire_valid) begin
            check_value("wb_en", 32'(wb_en), 32'd0);
            check_value("dmem_we", 32'(dmem_we), 32'd0);
        end else begin
            predict(program_mem[model_pc[7:2]]);
            check_value("imem_addr", imem_addr, model_pc);
            check_value("retire_pc", retire_pc, model_pc);
            check_value("wb_en", 32'(wb_en), 32'(exp_wb_en));
            if (exp_wb_en) begin
                check_value("wb_rd", 32'(wb_rd), 32'(exp_wb_rd));
                check_value("wb_data", wb_data, exp_wb_data);
            end
            check_value("dmem_we", 32'(dmem_we), 32'(exp_we));
            if (exp_we) begin
                check_value("dmem_addr", dmem_addr, exp_addr);
                check_value("dmem_wdata", dmem_wdata, exp_wdata);
            end
            commit_instruction();
            retired = retired + 1;
            if (retired == n_retire) begin
                $display(">>> PASS");
                $finish;
            end
        end
    end

endmodule
